//--- fetch_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared widths, vector types and opcode constants of the fetch unit
// every fetch module refers to these by scoped names
////////////////////////////////////////////////////////////////////////////
package fetch_pkg;

  // bundle geometry
  localparam int bundle_slots = 8;
  // direct-mapped branch target buffer size
  localparam int btb_entries  = 16;

  // major opcode sits in instruction bits 31:26
  localparam logic [5:0] opc_br      = 6'h30;
  // conditional branches own the top eight opcodes, 0x38 to 0x3f
  localparam logic [5:0] opc_cond_lo = 6'h38;

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  // instruction address
  typedef logic [63:0]  addr_t;
  // single instruction word
  typedef logic [31:0]  inst_t;
  // eight instructions, slot 0 in the low word
  typedef logic [255:0] bundle_t;
  // slot number inside a bundle
  typedef logic [2:0]   slot_t;
  // one valid bit per slot
  typedef logic [7:0]   slot_mask_t;
  // buffer index, address bits 8:5
  typedef logic [3:0]   btb_index_t;
  // buffer tag, address bits 63:9
  typedef logic [54:0]  btb_tag_t;

  ////////////////////////////////////////////////////////////////////////////
  // branch classification
  ////////////////////////////////////////////////////////////////////////////

  // no indirect kinds here, direction is static
  typedef enum logic [1:0] {
    br_none   = 2'd0,
    br_uncond = 2'd1,
    br_cond   = 2'd2
  } br_kind_e;

endpackage

//--- fetch_btb.sv
////////////////////////////////////////////////////////////////////////////
// direct-mapped branch target buffer for the fetch unit
// read is combinational on the f0 pc, write comes from f1 allocation
// and is seen by a read from the next cycle on
////////////////////////////////////////////////////////////////////////////
module fetch_btb (
  input  logic              clock,
  input  logic              reset_n,
  // f0 lookup
  input  fetch_pkg::addr_t  rd_pc_i,
  // f1 allocation
  input  logic              wr_en_i,
  input  fetch_pkg::addr_t  wr_pc_i,
  input  fetch_pkg::slot_t  wr_slot_i,
  input  logic              wr_taken_i,
  input  fetch_pkg::addr_t  wr_target_i,
  // lookup result
  output logic              hit_o,
  output fetch_pkg::slot_t  slot_o,
  output logic              taken_o,
  output fetch_pkg::addr_t  target_o
);

  // entry storage
  logic                 valid_q  [fetch_pkg::btb_entries];
  fetch_pkg::btb_tag_t  tag_q    [fetch_pkg::btb_entries];
  fetch_pkg::slot_t     slot_q   [fetch_pkg::btb_entries];
  logic                 taken_q  [fetch_pkg::btb_entries];
  fetch_pkg::addr_t     target_q [fetch_pkg::btb_entries];

  fetch_pkg::btb_index_t rd_idx;
  fetch_pkg::btb_tag_t   rd_tag;
  fetch_pkg::btb_index_t wr_idx;

  // index from bits 8:5, tag from the rest above
  assign rd_idx = rd_pc_i[8:5];
  assign rd_tag = rd_pc_i[63:9];
  assign wr_idx = wr_pc_i[8:5];

  ////////////////////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////////////////////

  // hit needs a live entry with a matching tag
  assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign slot_o   = slot_q[rd_idx];
  assign taken_o  = taken_q[rd_idx];
  assign target_o = target_q[rd_idx];

  ////////////////////////////////////////////////////////////////////////////
  // allocation
  ////////////////////////////////////////////////////////////////////////////

  // valid bits, cleared on reset
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < fetch_pkg::btb_entries; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else if (wr_en_i) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // entry payload
  // a write simply replaces whatever sat at that index
  always_ff @(posedge clock) begin
    if (wr_en_i) begin
      tag_q[wr_idx]    <= wr_pc_i[63:9];
      slot_q[wr_idx]   <= wr_slot_i;
      // direction fixed at allocation, never retrained
      taken_q[wr_idx]  <= wr_taken_i;
      target_q[wr_idx] <= wr_target_i;
    end
  end

endmodule

//--- fetch_f0_predict.sv
////////////////////////////////////////////////////////////////////////////
// f0 next-bundle pc and slot-valid mask from the buffer lookup
// purely combinational, drives the pc generator and the f0/f1 register
////////////////////////////////////////////////////////////////////////////
module fetch_f0_predict (
  input  logic                  hit_i,
  input  fetch_pkg::slot_t      slot_i,
  input  logic                  taken_i,
  input  fetch_pkg::addr_t      target_i,
  input  fetch_pkg::addr_t      pc_f0_i,
  output fetch_pkg::addr_t      branch_pc_o,
  output fetch_pkg::slot_mask_t slot_mask_o
);

  // address right after the predicted branch
  fetch_pkg::addr_t after_br_pc;
  // next aligned bundle
  fetch_pkg::addr_t next_bundle_pc;

  assign after_br_pc    = pc_f0_i + {59'd0, slot_i, 2'b00} + 64'd4;
  assign next_bundle_pc = pc_f0_i + 64'd32;

  ////////////////////////////////////////////////////////////////////////////
  // next pc select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (hit_i && taken_i) begin
      branch_pc_o = target_i;
    end else if (hit_i) begin
      // known branch, predicted to fall through
      branch_pc_o = after_br_pc;
    end else begin
      branch_pc_o = next_bundle_pc;
    end
  end

  // slots past a known branch are cut off
  // on a miss the whole bundle is kept
  always_comb begin
    for (int i = 0; i < fetch_pkg::bundle_slots; i++) begin
      slot_mask_o[i] = !hit_i || (fetch_pkg::slot_t'(i) <= slot_i);
    end
  end

endmodule

//--- branch_decode.sv
////////////////////////////////////////////////////////////////////////////
// f1 branch predecode of a fetched bundle
// finds the lowest branch slot, its kind, static direction and target,
// and the slot mask up to and including that branch
////////////////////////////////////////////////////////////////////////////
module branch_decode (
  input  fetch_pkg::addr_t      pc_f1_i,
  input  fetch_pkg::bundle_t    bundle_i,
  output logic                  exists_o,
  output fetch_pkg::br_kind_e   kind_o,
  output fetch_pkg::slot_t      slot_o,
  output logic                  taken_o,
  output fetch_pkg::addr_t      target_o,
  output fetch_pkg::slot_mask_t slot_mask_o
);

  // per-slot classification
  fetch_pkg::br_kind_e slot_kind [fetch_pkg::bundle_slots];
  logic [20:0]         slot_disp [fetch_pkg::bundle_slots];

  fetch_pkg::addr_t br_pc;
  fetch_pkg::addr_t disp_bytes;
  logic [20:0]      br_disp;

  ////////////////////////////////////////////////////////////////////////////
  // opcode classify, one decoder per slot
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    fetch_pkg::inst_t inst;
    for (int i = 0; i < fetch_pkg::bundle_slots; i++) begin
      inst = bundle_i[i*32 +: 32];
      slot_disp[i] = inst[20:0];
      if (inst[31:26] == fetch_pkg::opc_br) begin
        slot_kind[i] = fetch_pkg::br_uncond;
      end else if (inst[31:26] >= fetch_pkg::opc_cond_lo) begin
        slot_kind[i] = fetch_pkg::br_cond;
      end else begin
        slot_kind[i] = fetch_pkg::br_none;
      end
    end
  end

  // priority pick, scanning down so the lowest slot wins
  always_comb begin
    exists_o = 1'b0;
    kind_o   = fetch_pkg::br_none;
    slot_o   = '0;
    br_disp  = '0;
    for (int i = fetch_pkg::bundle_slots - 1; i >= 0; i--) begin
      if (slot_kind[i] != fetch_pkg::br_none) begin
        exists_o = 1'b1;
        kind_o   = slot_kind[i];
        slot_o   = fetch_pkg::slot_t'(i);
        br_disp  = slot_disp[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // target and static direction
  ////////////////////////////////////////////////////////////////////////////

  // word displacement, sign extended and scaled to bytes
  assign br_pc      = pc_f1_i + {59'd0, slot_o, 2'b00};
  assign disp_bytes = {{41{br_disp[20]}}, br_disp, 2'b00};
  assign target_o   = br_pc + 64'd4 + disp_bytes;

  // backward conditional taken, forward not taken
  assign taken_o = (kind_o == fetch_pkg::br_uncond) ||
                   ((kind_o == fetch_pkg::br_cond) && br_disp[20]);

  // keep slots up to the branch, all of them with no branch
  always_comb begin
    for (int i = 0; i < fetch_pkg::bundle_slots; i++) begin
      slot_mask_o[i] = !exists_o || (fetch_pkg::slot_t'(i) <= slot_o);
    end
  end

endmodule

//--- fetch_f1_stage.sv
////////////////////////////////////////////////////////////////////////////
// f0/f1 pipe register, f1 kill, decode override and buffer allocation,
// then the f1/d0 register toward the instruction buffer
////////////////////////////////////////////////////////////////////////////
module fetch_f1_stage (
  input  logic                  clock,
  input  logic                  reset_n,
  input  fetch_pkg::addr_t      pc_f0_i,
  input  fetch_pkg::addr_t      pc_f1_i,
  input  fetch_pkg::bundle_t    bundle_i,
  input  logic                  icache_stall_i,
  input  logic                  instbuf_full_i,
  input  logic                  flush_i,
  // f0 buffer lookup
  input  logic                  btb_hit_i,
  input  fetch_pkg::slot_t      btb_slot_i,
  input  logic                  btb_taken_i,
  input  fetch_pkg::addr_t      btb_target_i,
  input  fetch_pkg::slot_mask_t f0_mask_i,
  // f1 decode
  input  logic                  dec_exists_i,
  input  fetch_pkg::br_kind_e   dec_kind_i,
  input  fetch_pkg::slot_t      dec_slot_i,
  input  logic                  dec_taken_i,
  input  fetch_pkg::addr_t      dec_target_i,
  input  fetch_pkg::slot_mask_t dec_mask_i,
  // buffer allocation
  output logic                  btb_wr_en_o,
  output fetch_pkg::addr_t      btb_wr_pc_o,
  output fetch_pkg::slot_t      btb_wr_slot_o,
  output logic                  btb_wr_taken_o,
  output fetch_pkg::addr_t      btb_wr_target_o,
  // redirect to pc generator
  output logic                  override_vld_o,
  output fetch_pkg::addr_t      override_pc_o,
  // toward instruction buffer
  output fetch_pkg::slot_mask_t inst_vld_o,
  output fetch_pkg::bundle_t    inst_bundle_o
);

  logic                  advance;
  logic                  kill_f1;
  logic                  br_found;
  logic                  btb_valid_f1;
  logic                  btb_agrees;
  fetch_pkg::slot_mask_t vld_f1;

  // f1 copies of the f0 results
  fetch_pkg::slot_mask_t mask_f1;
  logic                  hit_f1;
  logic                  taken_f1;
  logic                  stall_f1;
  fetch_pkg::slot_t      slot_f1;
  fetch_pkg::addr_t      target_f1;
  fetch_pkg::addr_t      pc_f1_q;
  logic                  flush_q;
  logic                  override_q;

  // flush pushes through a full instruction buffer
  assign advance = !instbuf_full_i || flush_i;

  ////////////////////////////////////////////////////////////////////////////
  // f0 to f1
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      mask_f1  <= '0;
      hit_f1   <= 1'b0;
      taken_f1 <= 1'b0;
      stall_f1 <= 1'b0;
    end else if (advance) begin
      mask_f1  <= f0_mask_i;
      hit_f1   <= btb_hit_i;
      taken_f1 <= btb_taken_i;
      stall_f1 <= icache_stall_i;
    end
  end

  // lookup payload and the pc it was looked up for
  always_ff @(posedge clock) begin
    if (advance) begin
      slot_f1   <= btb_slot_i;
      target_f1 <= btb_target_i;
      pc_f1_q   <= pc_f0_i;
    end
  end

  // flush and override each kill the next f1
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      flush_q    <= 1'b0;
      override_q <= 1'b0;
    end else begin
      flush_q    <= flush_i;
      override_q <= override_vld_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // f1 decisions
  ////////////////////////////////////////////////////////////////////////////

  assign kill_f1 = !advance || stall_f1 || flush_i || flush_q || override_q;

  assign br_found = dec_exists_i && (dec_kind_i != fetch_pkg::br_none);

  // buffer result only counts for the bundle it was looked up for
  assign btb_valid_f1 = hit_f1 && (pc_f1_q == pc_f1_i);

  // buffer already steered f0 to this branch target
  assign btb_agrees = btb_valid_f1 && taken_f1 &&
                      (slot_f1 == dec_slot_i) && (target_f1 == dec_target_i);

  assign override_vld_o = !kill_f1 && br_found && dec_taken_i && !btb_agrees;
  assign override_pc_o  = dec_target_i;

  // allocate on a miss with the static direction
  assign btb_wr_en_o     = !kill_f1 && br_found && !btb_valid_f1;
  assign btb_wr_pc_o     = pc_f1_i;
  assign btb_wr_slot_o   = dec_slot_i;
  assign btb_wr_taken_o  = dec_taken_i;
  assign btb_wr_target_o = dec_target_i;

  always_comb begin
    if (kill_f1) begin
      vld_f1 = '0;
    end else if (br_found) begin
      vld_f1 = dec_mask_i;
    end else begin
      vld_f1 = mask_f1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // f1 to d0
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      inst_vld_o    <= '0;
      inst_bundle_o <= '0;
    end else if (advance) begin
      inst_vld_o    <= vld_f1;
      inst_bundle_o <= bundle_i;
    end
  end

endmodule

//--- fetch_top.sv
////////////////////////////////////////////////////////////////////////////
// two-stage instruction fetch unit
// f0 looks up the buffer and predicts the next bundle pc, f1 decodes
// the cache bundle and hands it to the instruction buffer
////////////////////////////////////////////////////////////////////////////
module fetch_top (
  input  logic                  clock,
  input  logic                  reset_n,
  input  fetch_pkg::addr_t      pc_f0_i,
  input  fetch_pkg::addr_t      pc_f1_i,
  input  fetch_pkg::bundle_t    inst_bundle_i,
  input  logic                  icache_stall_i,
  input  logic                  instbuf_full_i,
  input  logic                  flush_i,
  output fetch_pkg::addr_t      branch_pc_o,
  output logic                  override_vld_o,
  output fetch_pkg::addr_t      override_pc_o,
  output fetch_pkg::slot_mask_t inst_vld_o,
  output fetch_pkg::bundle_t    inst_bundle_o
);

  // buffer lookup
  logic                  btb_hit;
  fetch_pkg::slot_t      btb_slot;
  logic                  btb_taken;
  fetch_pkg::addr_t      btb_target;
  fetch_pkg::slot_mask_t f0_mask;

  // f1 decode
  logic                  dec_exists;
  fetch_pkg::br_kind_e   dec_kind;
  fetch_pkg::slot_t      dec_slot;
  logic                  dec_taken;
  fetch_pkg::addr_t      dec_target;
  fetch_pkg::slot_mask_t dec_mask;

  // allocation back into the buffer
  logic                  wr_en;
  fetch_pkg::addr_t      wr_pc;
  fetch_pkg::slot_t      wr_slot;
  logic                  wr_taken;
  fetch_pkg::addr_t      wr_target;

  fetch_btb u_btb (
    .clock       (clock),
    .reset_n     (reset_n),
    .rd_pc_i     (pc_f0_i),
    .wr_en_i     (wr_en),
    .wr_pc_i     (wr_pc),
    .wr_slot_i   (wr_slot),
    .wr_taken_i  (wr_taken),
    .wr_target_i (wr_target),
    .hit_o       (btb_hit),
    .slot_o      (btb_slot),
    .taken_o     (btb_taken),
    .target_o    (btb_target)
  );

  fetch_f0_predict u_f0_predict (
    .hit_i       (btb_hit),
    .slot_i      (btb_slot),
    .taken_i     (btb_taken),
    .target_i    (btb_target),
    .pc_f0_i     (pc_f0_i),
    .branch_pc_o (branch_pc_o),
    .slot_mask_o (f0_mask)
  );

  branch_decode u_branch_decode (
    .pc_f1_i     (pc_f1_i),
    .bundle_i    (inst_bundle_i),
    .exists_o    (dec_exists),
    .kind_o      (dec_kind),
    .slot_o      (dec_slot),
    .taken_o     (dec_taken),
    .target_o    (dec_target),
    .slot_mask_o (dec_mask)
  );

  fetch_f1_stage u_f1_stage (
    .clock           (clock),
    .reset_n         (reset_n),
    .pc_f0_i         (pc_f0_i),
    .pc_f1_i         (pc_f1_i),
    .bundle_i        (inst_bundle_i),
    .icache_stall_i  (icache_stall_i),
    .instbuf_full_i  (instbuf_full_i),
    .flush_i         (flush_i),
    .btb_hit_i       (btb_hit),
    .btb_slot_i      (btb_slot),
    .btb_taken_i     (btb_taken),
    .btb_target_i    (btb_target),
    .f0_mask_i       (f0_mask),
    .dec_exists_i    (dec_exists),
    .dec_kind_i      (dec_kind),
    .dec_slot_i      (dec_slot),
    .dec_taken_i     (dec_taken),
    .dec_target_i    (dec_target),
    .dec_mask_i      (dec_mask),
    .btb_wr_en_o     (wr_en),
    .btb_wr_pc_o     (wr_pc),
    .btb_wr_slot_o   (wr_slot),
    .btb_wr_taken_o  (wr_taken),
    .btb_wr_target_o (wr_target),
    .override_vld_o  (override_vld_o),
    .override_pc_o   (override_pc_o),
    .inst_vld_o      (inst_vld_o),
    .inst_bundle_o   (inst_bundle_o)
  );

endmodule

//--- tb_fetch.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the two-stage fetch unit
// seeded random traffic over a small pool of bundle addresses
// every output is compared each cycle with a buffer and pipe model
////////////////////////////////////////////////////////////////////////////
module tb_fetch;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int reset_cycles  = 10;
  localparam int pool_size     = 24;
  localparam int random_cycles = 400;
  localparam int hold_cycles   = 160;
  // stimulus length in cycles
  localparam int total_cycles  = reset_cycles + 2 * pool_size + random_cycles + hold_cycles;
  // watchdog limit at twice the stimulus length
  localparam int cycle_limit   = 2 * total_cycles;

  logic                  clock;
  logic                  reset_n;
  fetch_pkg::addr_t      pc_f0_i;
  fetch_pkg::addr_t      pc_f1_i;
  fetch_pkg::bundle_t    inst_bundle_i;
  logic                  icache_stall_i;
  logic                  instbuf_full_i;
  logic                  flush_i;
  fetch_pkg::addr_t      branch_pc_o;
  logic                  override_vld_o;
  fetch_pkg::addr_t      override_pc_o;
  fetch_pkg::slot_mask_t inst_vld_o;
  fetch_pkg::bundle_t    inst_bundle_o;

  fetch_top dut (
    .clock          (clock),
    .reset_n        (reset_n),
    .pc_f0_i        (pc_f0_i),
    .pc_f1_i        (pc_f1_i),
    .inst_bundle_i  (inst_bundle_i),
    .icache_stall_i (icache_stall_i),
    .instbuf_full_i (instbuf_full_i),
    .flush_i        (flush_i),
    .branch_pc_o    (branch_pc_o),
    .override_vld_o (override_vld_o),
    .override_pc_o  (override_pc_o),
    .inst_vld_o     (inst_vld_o),
    .inst_bundle_o  (inst_bundle_o)
  );

  int               seed = 94;
  fetch_pkg::addr_t pool [pool_size];
  // bundle address currently in f1
  fetch_pkg::addr_t f1_pc;
  int               cycle_count = 0;
  int               check_count = 0;
  int               err_count   = 0;
  int               test_err_base;
  int               test_cycle_base;
  // per-test event counts
  int               n_hit;
  int               n_override;
  int               n_alloc;
  int               n_kill;
  int               n_hold;

  // model buffer
  logic                m_valid  [fetch_pkg::btb_entries];
  fetch_pkg::btb_tag_t m_tag    [fetch_pkg::btb_entries];
  fetch_pkg::slot_t    m_slot   [fetch_pkg::btb_entries];
  logic                m_taken  [fetch_pkg::btb_entries];
  fetch_pkg::addr_t    m_target [fetch_pkg::btb_entries];

  // model pipe state
  fetch_pkg::slot_mask_t m_mask_f1;
  logic                  m_hit_f1;
  logic                  m_taken_f1;
  logic                  m_stall_f1;
  logic                  m_flush_q;
  logic                  m_override_q;
  fetch_pkg::slot_mask_t m_vld_out;
  fetch_pkg::bundle_t    m_bundle_out;

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  // cycle watchdog
  initial begin
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("timeout: run went past %0d clock cycles without finishing", cycle_limit);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic roll(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // cache contents as a fixed mix of plain and branch words per address
  function automatic fetch_pkg::bundle_t make_bundle(input fetch_pkg::addr_t pc);
    fetch_pkg::bundle_t b;
    logic [63:0]        h;
    logic [5:0]         opc;
    logic [20:0]        disp;
    for (int s = 0; s < fetch_pkg::bundle_slots; s++) begin
      h = (pc ^ (pc >> 29)) * 64'h9e3779b97f4a7c15 + 64'(s + 1) * 64'hbf58476d1ce4e5b9;
      h = h ^ (h >> 31);
      disp = {9'd0, h[27:16]};
      if (h[3:0] < 4'd10) begin
        // plain instruction with an opcode below the branch range
        opc = h[9:4] % 6'd48;
      end else if (h[3:0] < 4'd12) begin
        opc  = fetch_pkg::opc_br;
        disp = h[36:16];
      end else if (h[3:0] < 4'd14) begin
        opc = {3'b111, h[6:4]};
      end else begin
        // backward conditional
        opc  = {3'b111, h[6:4]};
        disp = ~{9'd0, h[27:16]};
      end
      b[s*32 +: 32] = {opc, h[52:48], disp};
    end
    return b;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // first branch of a bundle with its static direction and target
  task automatic decode(input fetch_pkg::addr_t pc, input fetch_pkg::bundle_t b,
                        output logic found, output fetch_pkg::slot_t slot,
                        output logic taken, output fetch_pkg::addr_t target,
                        output fetch_pkg::slot_mask_t mask);
    fetch_pkg::inst_t w;
    logic [20:0]      disp;
    logic             is_br;
    found  = 1'b0;
    slot   = '0;
    taken  = 1'b0;
    target = '0;
    mask   = 8'hff;
    for (int s = 0; s < fetch_pkg::bundle_slots; s++) begin
      w     = b[s*32 +: 32];
      is_br = (w[31:26] == fetch_pkg::opc_br) || (w[31:26] >= fetch_pkg::opc_cond_lo);
      if (is_br && !found) begin
        found  = 1'b1;
        slot   = 3'(s);
        disp   = w[20:0];
        taken  = (w[31:26] == fetch_pkg::opc_br) || disp[20];
        target = pc + 64'(4 * s + 4) + {{41{disp[20]}}, disp, 2'b00};
        mask   = 8'hff >> (7 - s);
      end
    end
  endtask

  task automatic model_reset();
    for (int i = 0; i < fetch_pkg::btb_entries; i++) begin
      m_valid[i] = 1'b0;
      m_taken[i] = 1'b0;
    end
    m_mask_f1    = '0;
    m_hit_f1     = 1'b0;
    m_taken_f1   = 1'b0;
    m_stall_f1   = 1'b0;
    m_flush_q    = 1'b0;
    m_override_q = 1'b0;
    m_vld_out    = '0;
    m_bundle_out = '0;
  endtask

  task automatic check_equal(input string what, input logic [255:0] got,
                             input logic [255:0] exp);
    check_count++;
    assert (got === exp) else begin
      err_count++;
      $display("[ERROR] t=%0d ns: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one clock cycle entered and left 2 ns after a rising edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic step(input fetch_pkg::addr_t pc, input logic stall, input logic full,
                      input logic flush, input logic first_fetch);
    fetch_pkg::btb_index_t idx;
    fetch_pkg::btb_index_t wr_idx;
    logic                  hit;
    logic                  hit_taken;
    fetch_pkg::addr_t      exp_pc;
    fetch_pkg::slot_mask_t f0_mask;
    logic                  found;
    fetch_pkg::slot_t      dslot;
    logic                  dtaken;
    fetch_pkg::addr_t      dtarget;
    fetch_pkg::slot_mask_t dmask;
    logic                  adv;
    logic                  kill;
    logic                  ovr;
    logic                  wr;
    fetch_pkg::slot_mask_t vld;
    pc_f0_i        = pc;
    pc_f1_i        = f1_pc;
    inst_bundle_i  = make_bundle(f1_pc);
    icache_stall_i = stall;
    instbuf_full_i = full;
    flush_i        = flush;
    #10;
    // f0 lookup
    idx       = pc[8:5];
    hit       = m_valid[idx] && (m_tag[idx] == pc[63:9]);
    hit_taken = hit && m_taken[idx];
    if (hit_taken) begin
      exp_pc = m_target[idx];
    end else if (hit) begin
      exp_pc = pc + {59'd0, m_slot[idx], 2'b00} + 64'd4;
    end else begin
      exp_pc = pc + 64'd32;
    end
    f0_mask = hit ? (8'hff >> (3'd7 - m_slot[idx])) : 8'hff;
    // f1 decisions
    decode(f1_pc, inst_bundle_i, found, dslot, dtaken, dtarget, dmask);
    adv  = !full || flush;
    kill = !adv || m_stall_f1 || flush || m_flush_q || m_override_q;
    ovr  = !kill && found && dtaken && !(m_hit_f1 && m_taken_f1);
    wr   = !kill && found && !m_hit_f1;
    if (kill) begin
      vld = '0;
    end else if (found) begin
      vld = dmask;
    end else begin
      vld = m_mask_f1;
    end
    check_equal("branch_pc_o", 256'(branch_pc_o), 256'(exp_pc));
    if (first_fetch) begin
      check_equal("branch_pc_o on first fetch", 256'(branch_pc_o), 256'(pc + 64'd32));
    end
    check_equal("override_vld_o", 256'(override_vld_o), 256'(ovr));
    if (ovr) begin
      check_equal("override_pc_o", 256'(override_pc_o), 256'(dtarget));
    end
    n_hit      += int'(hit);
    n_override += int'(ovr);
    n_alloc    += int'(wr);
    n_kill     += int'(kill && adv);
    n_hold     += int'(!adv);
    @(posedge clock);
    // model edge
    if (adv) begin
      m_mask_f1    = f0_mask;
      m_hit_f1     = hit;
      m_taken_f1   = hit_taken;
      m_stall_f1   = stall;
      m_vld_out    = vld;
      m_bundle_out = inst_bundle_i;
      f1_pc        = pc;
    end
    if (wr) begin
      wr_idx           = pc_f1_i[8:5];
      m_valid[wr_idx]  = 1'b1;
      m_tag[wr_idx]    = pc_f1_i[63:9];
      m_slot[wr_idx]   = dslot;
      m_taken[wr_idx]  = dtaken;
      m_target[wr_idx] = dtarget;
    end
    m_flush_q    = flush;
    m_override_q = ovr;
    #2;
    check_equal("inst_vld_o", 256'(inst_vld_o), 256'(m_vld_out));
    check_equal("inst_bundle_o", inst_bundle_o, m_bundle_out);
  endtask

  task automatic begin_test();
    n_hit           = 0;
    n_override      = 0;
    n_alloc         = 0;
    n_kill          = 0;
    n_hold          = 0;
    test_err_base   = err_count;
    test_cycle_base = cycle_count;
  endtask

  task automatic end_test(input string name);
    string counts;
    counts = $sformatf("%0d hits, %0d overrides, %0d allocs, %0d kills, %0d held",
                       n_hit, n_override, n_alloc, n_kill, n_hold);
    $display("test %s done in %0d cycles: %s, %0d errors", name,
             cycle_count - test_cycle_base, counts, err_count - test_err_base);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int hi;
    int lo;
    reset_n        = 1'b0;
    pc_f0_i        = '0;
    pc_f1_i        = '0;
    inst_bundle_i  = '0;
    icache_stall_i = 1'b0;
    instbuf_full_i = 1'b0;
    flush_i        = 1'b0;
    f1_pc          = '0;
    model_reset();
    // aligned pool with more addresses than buffer entries
    for (int i = 0; i < pool_size; i++) begin
      hi      = $random(seed);
      lo      = $random(seed);
      pool[i] = {hi[31:0], lo[31:5], 5'd0};
    end
    repeat (reset_cycles) @(posedge clock);
    #2;
    reset_n = 1'b1;

    begin_test();
    check_equal("inst_vld_o after reset", 256'(inst_vld_o), 256'(0));
    check_equal("inst_bundle_o after reset", inst_bundle_o, 256'(0));
    check_equal("branch_pc_o after reset", 256'(branch_pc_o), 256'(pc_f0_i + 64'd32));
    end_test("reset");

    // every address seen for the first time
    begin_test();
    for (int i = 0; i < pool_size; i++) begin
      step(pool[i], 1'b0, 1'b0, 1'b0, 1'b1);
    end
    end_test("miss_sweep");

    begin_test();
    for (int i = 0; i < pool_size; i++) begin
      step(pool[i], 1'b0, 1'b0, 1'b0, 1'b0);
    end
    check_count++;
    assert (n_hit > 0) else begin
      err_count++;
      $display("refetch sweep saw no buffer hits after the allocations");
    end
    end_test("refetch_sweep");

    begin_test();
    for (int c = 0; c < random_cycles; c++) begin
      step(pool[$unsigned($random(seed)) % pool_size], roll(10), roll(10), roll(5), 1'b0);
    end
    end_test("random_traffic");

    // heavy back-pressure with no flush to push through it
    begin_test();
    for (int c = 0; c < hold_cycles; c++) begin
      step(pool[$unsigned($random(seed)) % pool_size], roll(10), roll(50), 1'b0, 1'b0);
    end
    end_test("backpressure");

    $display("summary: %0d checks, %0d errors, %0d cycles", check_count, err_count,
             cycle_count);
    if (err_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
fetch_pkg.sv
fetch_btb.sv
fetch_f0_predict.sv
branch_decode.sv
fetch_f1_stage.sv
fetch_top.sv
tb_fetch.sv

//--- Makefile
# Verilator build and run of the fetch unit testbench
# any variable below can be overridden on the make command line

VERILATOR ?= verilator
TOP       ?= tb_fetch
RTL_TOP   ?= fetch_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS ?= --lint-only -Wall --timescale 1ns/1ps

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(filter-out $(TOP).sv,$(SRCS))
SIM_BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "RESULT: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
